/* source/alu_config.svh */
/* Build-time sizes and register map of the Wishbone ALU coprocessor.
   Included by every RTL file and by the testbench. */
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Operand and result width, whole bytes only
`define ALU_DATA_WIDTH 16
`define ALU_WB_WIDTH   32

// Word addresses, taken from wb_adr[4:2]
`define ALU_ADR_OPA    3'd0
`define ALU_ADR_OPB    3'd1
`define ALU_ADR_CTRL   3'd2
`define ALU_ADR_STATUS 3'd3
`define ALU_ADR_RESULT 3'd4
`define ALU_ADR_FLAGS  3'd5

`define ALU_CTRL_START_BIT  8  // Self-clearing
`define ALU_CTRL_IRQ_EN_BIT 9

`endif

/* source/alu_pkg.sv */
/* Operation codes and flag and status layouts shared by the ALU blocks
   and the testbench. */
package alu_pkg;

    // Codes 12 to 15 are not listed and give a zero result
    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_AND = 4'd2,
        OP_OR  = 4'd3,
        OP_XOR = 4'd4,
        OP_NOT = 4'd5,
        OP_SHL = 4'd6,
        OP_SHR = 4'd7,
        OP_SLT = 4'd8,   // Unsigned compare
        OP_EQ  = 4'd9,
        OP_MUL = 4'd10,  // a times b[7:0]
        OP_DIV = 4'd11   // b divided by a
    } alu_op_e;

    // FLAGS register layout, zero in bit 3
    typedef struct packed {
        logic zero;
        logic carry;     // Borrow for SUB
        logic overflow;  // Signed, ADD and SUB only
        logic negative;
    } alu_flags_t;

    // STATUS register bits [2:0]
    typedef struct packed {
        logic div_zero;  // Sticky
        logic done;      // Sticky, write 1 to clear
        logic busy;
    } alu_status_t;

endpackage

/* source/alu_if.sv */
/* Internal links of the coprocessor: request from the register block to the
   execution unit, and result from the execution unit to the output stage. */
`include "alu_config.svh"

interface alu_req_if;
    import alu_pkg::*;

    logic [`ALU_DATA_WIDTH-1:0] operand_a;
    logic [`ALU_DATA_WIDTH-1:0] operand_b;
    alu_op_e                    op;
    logic                       start;  // One-cycle pulse
    logic                       busy;

    modport src (
        output operand_a, operand_b, op, start
    );

    modport dst (
        input  operand_a, operand_b, op, start,
        output busy
    );
endinterface

interface alu_res_if;
    logic [`ALU_DATA_WIDTH-1:0] result;
    logic                       carry;
    logic                       overflow;
    logic                       div_zero;
    logic                       done;  // Result fields valid with this pulse

    modport src (
        output result, carry, overflow, div_zero, done
    );

    modport dst (
        input  result, carry, overflow, div_zero, done
    );
endinterface

/* source/alu_wb_regs.sv */
/* Wishbone classic slave of the ALU: operand and control registers, start and
   status-clear pulses, and the readback multiplexer for all six registers. */
`include "alu_config.svh"

module alu_wb_regs (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [`ALU_WB_WIDTH-1:0]    wb_adr,
    input  logic [`ALU_WB_WIDTH-1:0]    wb_dat_w,
    input  logic [`ALU_WB_WIDTH/8-1:0]  wb_sel,
    input  logic [`ALU_DATA_WIDTH-1:0]  result,
    input  alu_pkg::alu_flags_t         flags,
    input  alu_pkg::alu_status_t        status,
    output logic [`ALU_WB_WIDTH-1:0]    wb_dat_r,
    output logic                        wb_ack,
    output logic                        irq_en,
    output logic                        status_clear,
    alu_req_if.src                      req
);
    import alu_pkg::*;

    logic                       access;
    logic                       wr;
    logic [2:0]                 reg_sel;
    logic [`ALU_DATA_WIDTH-1:0] opa;
    logic [`ALU_DATA_WIDTH-1:0] opb;
    alu_op_e                    op;
    logic [`ALU_WB_WIDTH-1:0]   read_data;

    // Byte-lane merge of a bus write into an operand register
    function automatic logic [`ALU_DATA_WIDTH-1:0] merge_bytes(
        input logic [`ALU_DATA_WIDTH-1:0] old_val,
        input logic [`ALU_WB_WIDTH-1:0]   data,
        input logic [`ALU_WB_WIDTH/8-1:0] sel
    );
        logic [`ALU_DATA_WIDTH-1:0] merged;
        merged = old_val;
        for (int i = 0; i < `ALU_DATA_WIDTH/8; i++) begin
            if (sel[i]) begin
                merged[i*8 +: 8] = data[i*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign access  = wb_cyc && wb_stb && !wb_ack;  // One ack per strobe
    assign wr      = access && wb_we;
    assign reg_sel = wb_adr[4:2];

    assign req.operand_a = opa;
    assign req.operand_b = opb;
    assign req.op        = op;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (wr && reg_sel == `ALU_ADR_OPA) begin
            opa <= merge_bytes(opa, wb_dat_w, wb_sel);
        end
        if (wr && reg_sel == `ALU_ADR_OPB) begin
            opb <= merge_bytes(opb, wb_dat_w, wb_sel);
        end
        if (access && !wb_we) begin
            wb_dat_r <= read_data;  // Held through the ack cycle
        end
    end

    // CTRL byte 0 holds the op code, byte 1 the start and irq enable bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op           <= OP_ADD;
            irq_en       <= 1'b0;
            req.start    <= 1'b0;
            status_clear <= 1'b0;
        end else begin
            req.start    <= 1'b0;
            status_clear <= 1'b0;
            if (wr && reg_sel == `ALU_ADR_CTRL) begin
                if (wb_sel[0]) begin
                    op <= alu_op_e'(wb_dat_w[3:0]);
                end
                if (wb_sel[1]) begin
                    irq_en    <= wb_dat_w[`ALU_CTRL_IRQ_EN_BIT];
                    req.start <= wb_dat_w[`ALU_CTRL_START_BIT];
                end
            end
            if (wr && reg_sel == `ALU_ADR_STATUS && wb_sel[0]) begin
                status_clear <= wb_dat_w[1];  // Write 1 to the done bit
            end
        end
    end

    always_comb begin
        read_data = '0;
        case (reg_sel)
            `ALU_ADR_OPA:    read_data[`ALU_DATA_WIDTH-1:0] = opa;
            `ALU_ADR_OPB:    read_data[`ALU_DATA_WIDTH-1:0] = opb;
            `ALU_ADR_CTRL: begin
                read_data[3:0]                  = op;
                read_data[`ALU_CTRL_IRQ_EN_BIT] = irq_en;  // Start bit reads 0
            end
            `ALU_ADR_STATUS: read_data[$bits(alu_status_t)-1:0] = status;
            `ALU_ADR_RESULT: read_data[`ALU_DATA_WIDTH-1:0] = result;
            `ALU_ADR_FLAGS:  read_data[$bits(alu_flags_t)-1:0] = flags;
            default:         read_data = '0;
        endcase
    end

endmodule

/* source/alu_exec.sv */
/* Execution unit of the ALU. Single-step operations finish two cycles after
   start, the restoring divider takes one quotient bit per cycle. */
`include "alu_config.svh"

module alu_exec (
    input logic    clk,
    input logic    rst,
    alu_req_if.dst req,
    alu_res_if.src res
);
    import alu_pkg::*;

    localparam int DW = `ALU_DATA_WIDTH;
    localparam int SW = $clog2(DW);
    localparam logic [SW-1:0] LAST_STEP = SW'(DW - 1);

    typedef enum logic [1:0] {
        IDLE,
        EXECUTE,
        DIVIDE,
        RESULT
    } state_e;

    state_e          state;
    logic [SW-1:0]   step_q;
    logic [DW-1:0]   a_q;
    logic [DW-1:0]   b_q;
    alu_op_e         op_q;
    logic [DW-1:0]   quot_q;
    logic [DW-1:0]   rem_q;

    logic [DW:0]     sum;
    logic [DW:0]     diff;
    logic [DW+7:0]   product;
    logic [DW-1:0]   exe_result;
    logic            exe_carry;
    logic            exe_overflow;

    logic [DW:0]     div_shift;
    logic [DW:0]     div_trial;
    logic            div_fits;
    logic [DW-1:0]   rem_next;
    logic [DW-1:0]   quot_next;

    always_comb begin
        sum          = {1'b0, a_q} + {1'b0, b_q};
        diff         = {1'b0, a_q} - {1'b0, b_q};  // Top bit is the borrow
        product      = {8'b0, a_q} * {{DW{1'b0}}, b_q[7:0]};
        exe_result   = '0;
        exe_carry    = 1'b0;
        exe_overflow = 1'b0;
        case (op_q)
            OP_ADD: begin
                exe_result   = sum[DW-1:0];
                exe_carry    = sum[DW];
                exe_overflow = (a_q[DW-1] == b_q[DW-1]) && (sum[DW-1] != a_q[DW-1]);
            end
            OP_SUB: begin
                exe_result   = diff[DW-1:0];
                exe_carry    = diff[DW];
                exe_overflow = (a_q[DW-1] != b_q[DW-1]) && (diff[DW-1] != a_q[DW-1]);
            end
            OP_AND: exe_result = a_q & b_q;
            OP_OR:  exe_result = a_q | b_q;
            OP_XOR: exe_result = a_q ^ b_q;
            OP_NOT: exe_result = ~a_q;
            OP_SHL: begin
                exe_result = {a_q[DW-2:0], 1'b0};
                exe_carry  = a_q[DW-1];  // Bit leaving the top
            end
            OP_SHR: begin
                exe_result = {1'b0, a_q[DW-1:1]};
                exe_carry  = a_q[0];
            end
            OP_SLT: exe_result = {{(DW-1){1'b0}}, a_q < b_q};
            OP_EQ:  exe_result = {{(DW-1){1'b0}}, a_q == b_q};
            OP_MUL: begin
                exe_result = product[DW-1:0];
                exe_carry  = |product[DW+7:DW];  // Product wider than DW
            end
            default: exe_result = '0;  // DIV has its own state
        endcase
    end

    // One restoring step, dividend bits enter from the quotient register
    assign div_shift = {rem_q, quot_q[DW-1]};
    assign div_trial = div_shift - {1'b0, a_q};
    assign div_fits  = !div_trial[DW];
    assign rem_next  = div_fits ? div_trial[DW-1:0] : div_shift[DW-1:0];
    assign quot_next = {quot_q[DW-2:0], div_fits};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            step_q   <= '0;
            req.busy <= 1'b0;
            res.done <= 1'b0;
        end else begin
            res.done <= 1'b0;
            case (state)
                IDLE: begin
                    if (req.start) begin  // Ignored in every other state
                        req.busy <= 1'b1;
                        step_q   <= '0;
                        state    <= (req.op == OP_DIV) ? DIVIDE : EXECUTE;
                    end
                end
                EXECUTE: begin
                    res.done <= 1'b1;
                    state    <= RESULT;
                end
                DIVIDE: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == LAST_STEP) begin
                        res.done <= 1'b1;
                        state    <= RESULT;
                    end
                end
                default: begin
                    req.busy <= 1'b0;  // RESULT, done is high this cycle
                    state    <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (req.start) begin
                    a_q    <= req.operand_a;  // Bus may rewrite from here on
                    b_q    <= req.operand_b;
                    op_q   <= req.op;
                    quot_q <= req.operand_b;
                    rem_q  <= '0;
                end
            end
            EXECUTE: begin
                res.result   <= exe_result;
                res.carry    <= exe_carry;
                res.overflow <= exe_overflow;
                res.div_zero <= 1'b0;
            end
            DIVIDE: begin
                quot_q <= quot_next;
                rem_q  <= rem_next;
                if (step_q == LAST_STEP) begin
                    res.result   <= (a_q == '0) ? '0 : quot_next;
                    res.carry    <= 1'b0;
                    res.overflow <= 1'b0;
                    res.div_zero <= (a_q == '0);
                end
            end
            default: ;
        endcase
    end

endmodule

/* source/alu_result_stage.sv */
/* Output stage of the ALU: holds the last result and its flags, keeps the
   sticky done and divide-by-zero bits, and raises the interrupt. */
`include "alu_config.svh"

module alu_result_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        irq_en,
    input  logic                        status_clear,
    input  logic                        busy,
    output logic [`ALU_DATA_WIDTH-1:0]  result,
    output alu_pkg::alu_flags_t         flags,
    output alu_pkg::alu_status_t        status,
    output logic                        irq,
    alu_res_if.dst                      res
);
    import alu_pkg::*;

    alu_flags_t flags_next;
    logic       done_q;
    logic       div_zero_q;

    // Zero and negative come from the result, the rest from the execution unit
    always_comb begin
        flags_next.zero     = (res.result == '0);
        flags_next.carry    = res.carry;
        flags_next.overflow = res.overflow;
        flags_next.negative = res.result[`ALU_DATA_WIDTH-1];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result     <= '0;
            flags      <= '0;
            done_q     <= 1'b0;
            div_zero_q <= 1'b0;
            irq        <= 1'b0;
        end else begin
            if (res.done) begin
                result <= res.result;
                flags  <= flags_next;
            end

            // A new completion wins over a clear in the same cycle
            if (res.done) begin
                done_q <= 1'b1;
            end else if (status_clear) begin
                done_q <= 1'b0;
            end

            if (res.done && res.div_zero) begin
                div_zero_q <= 1'b1;
            end else if (status_clear) begin
                div_zero_q <= 1'b0;
            end

            irq <= done_q && irq_en;
        end
    end

    assign status = '{div_zero: div_zero_q, done: done_q, busy: busy};

endmodule

/* source/alu_host_top.sv */
/* Top level of the Wishbone ALU coprocessor. Connects the register block,
   the execution unit and the output stage. */
`include "alu_config.svh"

module alu_host_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [`ALU_WB_WIDTH-1:0]    wb_adr,
    input  logic [`ALU_WB_WIDTH-1:0]    wb_dat_w,
    input  logic [`ALU_WB_WIDTH/8-1:0]  wb_sel,
    output logic [`ALU_WB_WIDTH-1:0]    wb_dat_r,
    output logic                        wb_ack,
    output logic                        irq
);
    import alu_pkg::*;

    logic [`ALU_DATA_WIDTH-1:0] result;
    alu_flags_t                 flags;
    alu_status_t                status;
    logic                       irq_en;
    logic                       status_clear;

    alu_req_if req_bus ();
    alu_res_if res_bus ();

    alu_wb_regs u_regs (
        .clk          (clk),
        .rst          (rst),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_sel       (wb_sel),
        .result       (result),
        .flags        (flags),
        .status       (status),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .irq_en       (irq_en),
        .status_clear (status_clear),
        .req          (req_bus.src)
    );

    alu_exec u_exec (
        .clk (clk),
        .rst (rst),
        .req (req_bus.dst),
        .res (res_bus.src)
    );

    alu_result_stage u_result (
        .clk          (clk),
        .rst          (rst),
        .irq_en       (irq_en),
        .status_clear (status_clear),
        .busy         (req_bus.busy),  // Shown in STATUS bit 0
        .result       (result),
        .flags        (flags),
        .status       (status),
        .irq          (irq),
        .res          (res_bus.dst)
    );

endmodule

/* tests/alu_host_chk.sv */
/* Concurrent checks on the Wishbone handshake, the interrupt and the busy
   bit of the ALU coprocessor, bound into the top level by the testbench. */
module alu_host_chk (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic irq,
    input logic irq_en,
    input logic busy
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;  // Failed assertions so far

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else begin
            fail_count++;
            $error("wb_ack stayed high for more than one cycle");
        end

    // Ack only answers a strobe seen on the edge before
    ack_needs_strobe: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else begin
            fail_count++;
            $error("wb_ack rose without wb_cyc and wb_stb");
        end

    irq_needs_enable: assert property (@(posedge clk) disable iff (rst)
        irq |-> $past(irq_en))
        else begin
            fail_count++;
            $error("irq went high while the irq enable bit was low");
        end

    busy_bounded: assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> ##[1:18] !busy)
        else begin
            fail_count++;
            $error("busy stayed high for more than 18 cycles");
        end

endmodule

/* tests/alu_host_tb.sv */
/* Directed testbench of the Wishbone ALU coprocessor. Drives the bus on the
   falling clock edge and compares every reply with a reference model. */
`include "alu_config.svh"

module alu_host_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import alu_pkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int ACK_LIMIT      = 8;
    localparam int POLL_LIMIT     = 30;
    localparam int OP_BUDGET      = 16 * 36 + 30;  // Operations started by all tests
    localparam int TIMEOUT_CYCLES = OP_BUDGET * 40 + 500;

    logic                         clk;
    logic                         rst;
    logic                         wb_cyc;
    logic                         wb_stb;
    logic                         wb_we;
    logic [`ALU_WB_WIDTH-1:0]     wb_adr;
    logic [`ALU_WB_WIDTH-1:0]     wb_dat_w;
    logic [`ALU_WB_WIDTH/8-1:0]   wb_sel;
    logic [`ALU_WB_WIDTH-1:0]     wb_dat_r;
    logic                         wb_ack;
    logic                         irq;
    logic                         irq_high_seen;
    int                           errors;
    int                           checks;
    integer                       seed = 53864;

    alu_host_top DUT (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .irq      (irq)
    );

    bind alu_host_top alu_host_chk u_chk (
        .clk    (clk),
        .rst    (rst),
        .wb_cyc (wb_cyc),
        .wb_stb (wb_stb),
        .wb_ack (wb_ack),
        .irq    (irq),
        .irq_en (irq_en),
        .busy   (status.busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (irq === 1'b1) irq_high_seen <= 1'b1;
    end

    // Expected {zero, carry, overflow, negative, result} from the operation rules
    function automatic logic [19:0] ref_model(input logic [3:0] op, input logic [15:0] a,
                                              input logic [15:0] b);
        logic [15:0] r;
        logic        carry;
        logic        ovf;
        int          s;
        int unsigned p;
        r     = '0;
        carry = 1'b0;
        ovf   = 1'b0;
        case (op)
            OP_ADD: begin
                p     = a + b;
                s     = $signed(a) + $signed(b);
                r     = 16'(p);
                carry = p > 32'hFFFF;
                ovf   = (s > 32767) || (s < -32768);
            end
            OP_SUB: begin
                s     = $signed(a) - $signed(b);
                r     = a - b;
                carry = a < b;  // Borrow
                ovf   = (s > 32767) || (s < -32768);
            end
            OP_AND: r = a & b;
            OP_OR:  r = a | b;
            OP_XOR: r = a ^ b;
            OP_NOT: r = ~a;
            OP_SHL: begin
                r     = a << 1;
                carry = a[15];
            end
            OP_SHR: begin
                r     = a >> 1;
                carry = a[0];
            end
            OP_SLT: r = (a < b) ? 16'd1 : 16'd0;
            OP_EQ:  r = (a == b) ? 16'd1 : 16'd0;
            OP_MUL: begin
                p     = a * b[7:0];
                r     = 16'(p);
                carry = p > 32'hFFFF;
            end
            OP_DIV: r = (a == 16'd0) ? 16'd0 : b / a;
            default: r = '0;
        endcase
        return {r == 16'd0, carry, ovf, r[15], r};
    endfunction

    function automatic logic [31:0] ctrl_word(input logic [3:0] op, input logic start,
                                              input logic irq_on);
        logic [31:0] w;
        w = {28'd0, op};
        w[`ALU_CTRL_START_BIT]  = start;
        w[`ALU_CTRL_IRQ_EN_BIT] = irq_on;
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
        end
    endtask

    task automatic bus_cycle(input logic we, input logic [2:0] reg_idx, input logic [31:0] data,
                             input logic [3:0] sel, output logic [31:0] rdata);
        int waited;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = '0;
        wb_adr[4:2] = reg_idx;
        wb_dat_w = data;
        wb_sel   = sel;
        waited   = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (wb_ack !== 1'b1 && waited < ACK_LIMIT);
        assert (wb_ack === 1'b1) else begin
            errors++;
            $display("Bus access to register %0d got no acknowledge at %0t ns", reg_idx, $time);
        end
        rdata  = wb_dat_r;  // Valid while ack is high
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [2:0] reg_idx, input logic [31:0] data,
                            input logic [3:0] sel);
        logic [31:0] unused;
        bus_cycle(1'b1, reg_idx, data, sel, unused);
    endtask

    task automatic wb_read(input logic [2:0] reg_idx, output logic [31:0] rdata);
        bus_cycle(1'b0, reg_idx, '0, 4'hF, rdata);
    endtask

    task automatic wait_done(output logic [2:0] status);
        logic [31:0] rdata;
        int          polls;
        polls = 0;
        do begin
            wb_read(`ALU_ADR_STATUS, rdata);
            polls++;
        end while (rdata[1] !== 1'b1 && polls < POLL_LIMIT);
        assert (rdata[1] === 1'b1) else begin
            errors++;
            $display("Operation never reported done after %0d status polls", polls);
        end
        status = rdata[2:0];
    endtask

    task automatic run_op(input logic [3:0] op, input logic [15:0] a, input logic [15:0] b,
                          input logic irq_on, output logic [15:0] result,
                          output logic [3:0] flags, output logic [2:0] status);
        logic [31:0] rdata;
        wb_write(`ALU_ADR_OPA, {16'd0, a}, 4'hF);
        wb_write(`ALU_ADR_OPB, {16'd0, b}, 4'hF);
        wb_write(`ALU_ADR_CTRL, ctrl_word(op, 1'b1, irq_on), 4'hF);
        wait_done(status);
        wb_read(`ALU_ADR_RESULT, rdata);
        result = rdata[15:0];
        wb_read(`ALU_ADR_FLAGS, rdata);
        flags = rdata[3:0];
    endtask

    task automatic verify_op(input logic [3:0] op, input logic [15:0] a, input logic [15:0] b);
        logic [19:0] expected;
        logic [15:0] result;
        logic [3:0]  flags;
        logic [2:0]  status;
        expected = ref_model(op, a, b);
        run_op(op, a, b, 1'b0, result, flags, status);
        check_value("RESULT", result, expected[15:0]);
        check_value("FLAGS", flags, expected[19:16]);
        check_value("STATUS", status, {(op == OP_DIV) && (a == 16'd0), 2'b10});
        wb_write(`ALU_ADR_STATUS, 32'h2, 4'h1);  // Clear done and div_zero
    endtask

    task automatic wait_irq(input logic level);
        int waited;
        waited = 0;
        while (irq !== level && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        assert (irq === level) else begin
            errors++;
            $display("irq did not go to %0b within 8 cycles at %0t ns", level, $time);
        end
    endtask

    task automatic readback_registers();
        logic [31:0] rdata;
        wb_read(`ALU_ADR_STATUS, rdata);
        check_value("STATUS", rdata, 32'h0);
        wb_read(`ALU_ADR_RESULT, rdata);
        check_value("RESULT", rdata, 32'h0);
        wb_read(`ALU_ADR_FLAGS, rdata);
        check_value("FLAGS", rdata, 32'h0);
        wb_write(`ALU_ADR_OPA, 32'h0000_1234, 4'hF);
        wb_write(`ALU_ADR_OPA, 32'h0000_ABCD, 4'h2);  // Upper byte only
        wb_read(`ALU_ADR_OPA, rdata);
        check_value("OPA", rdata, 32'h0000_AB34);
        wb_write(`ALU_ADR_OPB, 32'hFFFF_5A5A, 4'hF);
        wb_write(`ALU_ADR_OPB, 32'h0000_00C3, 4'h1);
        wb_read(`ALU_ADR_OPB, rdata);
        check_value("OPB", rdata, 32'h0000_5AC3);
        wb_write(`ALU_ADR_CTRL, ctrl_word(4'd7, 1'b0, 1'b1), 4'h3);
        wb_write(`ALU_ADR_CTRL, 32'h0000_0003, 4'h1);  // Op code byte only
        wb_read(`ALU_ADR_CTRL, rdata);
        check_value("CTRL", rdata, 32'h0000_0203);
        wb_write(`ALU_ADR_CTRL, 32'h0, 4'h3);
    endtask

    task automatic sweep_all_ops();
        logic [15:0] corners [4];
        logic [15:0] a;
        logic [15:0] b;
        corners = '{16'h0000, 16'hFFFF, 16'h8000, 16'h7FFF};
        for (int op = 0; op < 16; op++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    verify_op(4'(op), corners[i], corners[j]);
                end
            end
            for (int k = 0; k < 20; k++) begin
                a = 16'($random(seed));
                b = 16'($random(seed));
                verify_op(4'(op), a, b);
            end
        end
    endtask

    task automatic divide_cases();
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] result;
        logic [3:0]  flags;
        logic [2:0]  status;
        logic [31:0] rdata;
        for (int k = 0; k < 20; k++) begin
            a = 16'($random(seed)) >> (k % 12);  // Spread of divisor sizes
            b = 16'($random(seed));
            verify_op(OP_DIV, a, b);
        end
        run_op(OP_DIV, 16'd0, 16'h1234, 1'b0, result, flags, status);
        check_value("RESULT", result, 32'h0);
        check_value("FLAGS", flags, 32'h8);  // Zero result, no carry
        check_value("STATUS", status, 3'b110);
        wb_write(`ALU_ADR_STATUS, 32'h2, 4'h1);
        wb_read(`ALU_ADR_STATUS, rdata);
        check_value("STATUS", rdata[2:0], 3'b000);
    endtask

    task automatic busy_protection();
        logic [19:0] expected;
        logic [31:0] rdata;
        logic [2:0]  status;
        expected = ref_model(OP_DIV, 16'd7, 16'd1000);
        wb_write(`ALU_ADR_OPA, 32'd7, 4'hF);
        wb_write(`ALU_ADR_OPB, 32'd1000, 4'hF);
        wb_write(`ALU_ADR_CTRL, ctrl_word(OP_DIV, 1'b1, 1'b0), 4'hF);
        wb_read(`ALU_ADR_STATUS, rdata);
        check_value("STATUS.busy", rdata[0], 1'b1);
        // New operands and a second start while the divide runs
        wb_write(`ALU_ADR_OPA, 32'd3, 4'hF);
        wb_write(`ALU_ADR_OPB, 32'd9, 4'hF);
        wb_write(`ALU_ADR_CTRL, ctrl_word(OP_ADD, 1'b1, 1'b0), 4'hF);
        wait_done(status);
        check_value("STATUS", status, 3'b010);
        wb_read(`ALU_ADR_RESULT, rdata);
        check_value("RESULT", rdata, {16'd0, expected[15:0]});
        wb_read(`ALU_ADR_FLAGS, rdata);
        check_value("FLAGS", rdata, {28'd0, expected[19:16]});
        wb_write(`ALU_ADR_STATUS, 32'h2, 4'h1);
        wb_read(`ALU_ADR_STATUS, rdata);
        check_value("STATUS", rdata, 32'h0);  // Ignored start left no second result
    endtask

    task automatic interrupt_cycle();
        logic [19:0] expected;
        logic [15:0] result;
        logic [3:0]  flags;
        logic [2:0]  status;
        irq_high_seen = 1'b0;
        verify_op(OP_ADD, 16'h1111, 16'h2222);  // Enable bit clear
        check_value("irq", irq_high_seen, 1'b0);
        expected = ref_model(OP_XOR, 16'h0F0F, 16'h00FF);
        run_op(OP_XOR, 16'h0F0F, 16'h00FF, 1'b1, result, flags, status);
        check_value("RESULT", result, {16'd0, expected[15:0]});
        check_value("FLAGS", flags, {28'd0, expected[19:16]});
        check_value("STATUS", status, 3'b010);
        wait_irq(1'b1);
        wb_write(`ALU_ADR_STATUS, 32'h2, 4'h1);
        wait_irq(1'b0);
        wb_write(`ALU_ADR_CTRL, ctrl_word(OP_ADD, 1'b0, 1'b0), 4'hF);
    endtask

    initial begin
        rst           = 1'b1;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_w      = '0;
        wb_sel        = '0;
        irq_high_seen = 1'b0;
        errors        = 0;
        checks        = 0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        readback_registers();
        sweep_all_ops();
        divide_cases();
        busy_protection();
        interrupt_cycle();
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, DUT.u_chk.fail_count);
        if (errors == 0 && DUT.u_chk.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Ends a hung run
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        errors++;
        $display("Watchdog expired after %0d cycles before the tests finished", TIMEOUT_CYCLES);
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, DUT.u_chk.fail_count);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* alu_host_top.f */
+incdir+source
source/alu_pkg.sv
source/alu_if.sv
source/alu_wb_regs.sv
source/alu_exec.sv
source/alu_result_stage.sv
source/alu_host_top.sv
tests/alu_host_chk.sv
tests/alu_host_tb.sv

/* Bender.yml */
package:
  name: alu_host_top

export_include_dirs:
  - source

sources:
  - files:
      - source/alu_pkg.sv
      - source/alu_if.sv
      - source/alu_wb_regs.sv
      - source/alu_exec.sv
      - source/alu_result_stage.sv
      - source/alu_host_top.sv
  - target: test
    files:
      - tests/alu_host_chk.sv
      - tests/alu_host_tb.sv
